// File: source/iopage_defs.svh
// I/O page constants
// device offsets within the 8 KB page, line clock rate and the clock vector

`ifndef IOPAGE_DEFS_SVH
`define IOPAGE_DEFS_SVH

// line clock status at 777546
`define LKS_OFFSET      13'h1F66

// switch and display register at 777570
`define SR_OFFSET       13'h1F78

// cpu error register at 777766
`define CPUERR_OFFSET   13'h1FF6

// processor status word at 777776
`define PSW_OFFSET      13'h1FFE

// at least 2 clk cycles per line clock tick
`define LINE_CLK_DIV    64

// line clock interrupt vector (100 octal)
`define CLK_VECTOR      8'h40

// read value with no device selected
`define NO_DEVICE_DATA  16'h0000

`endif

// File: source/iopage_pkg.sv
// I/O page types
// PSW layout and register bit positions shared by the devices

package iopage_pkg;

   // PSW by field from the msb down
   typedef struct packed
   {
      logic [1:0] cur_mode;
      logic [1:0] prev_mode;
      logic       reg_set;
      logic [2:0] reserved;
      logic [2:0] prio;
      logic       t;
      logic       n;
      logic       z;
      logic       v;
      logic       c;
   } psw_fields_t;

   // same word seen whole or by field
   typedef union packed
   {
      logic [15:0] raw;
      psw_fields_t fields;
   } psw_word_u;

   // line clock status bits
   localparam int LKS_MONITOR_BIT = 7;
   localparam int LKS_IE_BIT = 6;

   // cpu error register bits
   localparam int CPUERR_NXM_BIT = 5;
   localparam int CPUERR_UTO_BIT = 4;

endpackage

// File: source/iopage_bus_if.sv
// I/O page request bus
// carries the page offset, write data and strobes from the page to each device

`timescale 1ns/10ps

interface iopage_bus_if;

   logic [12:0] iopage_addr;
   logic [15:0] data_in;
   logic        iopage_rd;
   logic        iopage_wr;
   logic        iopage_byte_op;

   modport page
   (
      output iopage_addr,
      output data_in,
      output iopage_rd,
      output iopage_wr,
      output iopage_byte_op
   );

   modport device
   (
      input iopage_addr,
      input data_in,
      input iopage_rd,
      input iopage_wr,
      input iopage_byte_op
   );

endinterface

// File: source/clk_regs.sv
// line clock
// divides clk down to a periodic tick, holds LKS and raises the clock interrupt

`timescale 1ns/10ps
`include "iopage_defs.svh"

module clk_regs
   import iopage_pkg::*;
(
   input  logic               clk,
   input  logic               reset,
   iopage_bus_if.device       bus,
   output logic [15:0]        data_out,
   output logic               decode,
   output logic               interrupt_req,
   input  logic               interrupt_ack
);

   localparam int DIV_W = $clog2(`LINE_CLK_DIV);

   logic [DIV_W-1:0] div_count;
   logic             tick;
   logic             monitor;
   logic             ie;
   logic             hit;
   logic             lks_wr;

   // both status bits live in the low byte
   assign hit = (bus.iopage_addr[12:1] == 12'(`LKS_OFFSET >> 1));
   assign decode = hit & (bus.iopage_rd | bus.iopage_wr);
   assign lks_wr = hit & bus.iopage_wr & ~(bus.iopage_byte_op & bus.iopage_addr[0]);

   assign tick = (div_count == DIV_W'(`LINE_CLK_DIV - 1));

   always_ff @(posedge clk)
   begin
      if (reset)
         div_count <= '0;
      else if (tick)
         div_count <= '0;
      else
         div_count <= div_count + 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         monitor <= 1'b0;
         ie <= 1'b0;
      end
      else
      begin
         if (lks_wr)
         begin
            ie <= bus.data_in[LKS_IE_BIT];
            if (!bus.data_in[LKS_MONITOR_BIT])
               monitor <= 1'b0;
         end
         // tick wins over a clearing write
         if (tick)
            monitor <= 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         interrupt_req <= 1'b0;
      else if (lks_wr && !bus.data_in[LKS_IE_BIT])
         interrupt_req <= 1'b0;
      else if (tick && ie)
         interrupt_req <= 1'b1;
      else if (interrupt_ack)
         interrupt_req <= 1'b0;
   end

   always_comb
   begin
      data_out = '0;
      data_out[LKS_MONITOR_BIT] = monitor;
      data_out[LKS_IE_BIT] = ie;
   end

endmodule

// File: source/sr_regs.sv
// switch, display and cpu error registers
// sticky bus and memory timeout flags, display loaded byte-wise

`timescale 1ns/10ps
`include "iopage_defs.svh"

module sr_regs
   import iopage_pkg::*;
(
   input  logic               clk,
   input  logic               reset,
   iopage_bus_if.device       bus,
   output logic [15:0]        data_out,
   output logic               decode,
   input  logic [15:0]        switches,
   input  logic               unibus_to,
   input  logic               memory_to,
   output logic [15:0]        display
);

   logic sr_hit;
   logic cpuerr_hit;
   logic uto_err;
   logic nxm_err;
   logic [15:0] cpuerr_word;

   assign sr_hit = (bus.iopage_addr[12:1] == 12'(`SR_OFFSET >> 1));
   assign cpuerr_hit = (bus.iopage_addr[12:1] == 12'(`CPUERR_OFFSET >> 1));
   assign decode = (sr_hit | cpuerr_hit) & (bus.iopage_rd | bus.iopage_wr);

   always_ff @(posedge clk)
   begin
      if (reset)
         display <= '0;
      else if (sr_hit && bus.iopage_wr)
      begin
         if (!bus.iopage_byte_op)
            display <= bus.data_in;
         else if (bus.iopage_addr[0])
            display[15:8] <= bus.data_in[15:8];
         else
            display[7:0] <= bus.data_in[7:0];
      end
   end

   // timeouts stick until software writes the register
   always_ff @(posedge clk)
   begin
      if (reset || (cpuerr_hit && bus.iopage_wr))
      begin
         uto_err <= 1'b0;
         nxm_err <= 1'b0;
      end
      else
      begin
         if (unibus_to)
            uto_err <= 1'b1;
         if (memory_to)
            nxm_err <= 1'b1;
      end
   end

   always_comb
   begin
      cpuerr_word = '0;
      cpuerr_word[CPUERR_UTO_BIT] = uto_err;
      cpuerr_word[CPUERR_NXM_BIT] = nxm_err;
   end

   assign data_out = sr_hit ? switches : cpuerr_word;

endmodule

// File: source/psw_regs.sv
// PSW window
// reads the processor status word and forms the masked word for an I/O page write

`timescale 1ns/10ps
`include "iopage_defs.svh"

module psw_regs
   import iopage_pkg::*;
(
   input  logic               clk,
   input  logic               reset,
   iopage_bus_if.device       bus,
   output logic [15:0]        data_out,
   output logic               decode,
   input  logic [15:0]        psw_in,
   output logic               psw_io_wr,
   output logic [15:0]        psw_wr_data
);

   logic      hit;
   psw_word_u cur_psw;
   psw_word_u merged;
   logic [15:0] last_wr;
   logic        wr_pending;

   assign hit = (bus.iopage_addr[12:1] == 12'(`PSW_OFFSET >> 1));
   assign decode = hit & (bus.iopage_rd | bus.iopage_wr);
   assign psw_io_wr = hit & bus.iopage_wr;

   assign cur_psw.raw = psw_in;

   always_comb
   begin
      merged.raw = psw_in;
      if (!bus.iopage_byte_op)
         merged.raw = bus.data_in;
      else if (bus.iopage_addr[0])
         merged.raw[15:8] = bus.data_in[15:8];
      else
         merged.raw[7:0] = bus.data_in[7:0];
      // T bit only changes by rti/rtt or a trap
      merged.fields.t = cur_psw.fields.t;
   end

   assign psw_wr_data = merged.raw;

   // bridges the cycle while the processor psw settles after the write edge
   always_ff @(posedge clk)
   begin
      if (reset)
         wr_pending <= 1'b0;
      else
         wr_pending <= psw_io_wr;
   end

   always_ff @(posedge clk)
   begin
      if (psw_io_wr)
         last_wr <= merged.raw;
   end

   // write cycle itself still reads the live psw
   assign data_out = wr_pending ? last_wr : psw_in;

endmodule

// File: source/iopage.sv
// I/O page
// decodes the page offset onto the register devices, muxes read data
// and merges device interrupt requests into an ipl mask and vector

`timescale 1ns/10ps
`include "iopage_defs.svh"

module iopage
(
   input  logic        clk,
   input  logic        reset,
   input  logic [21:0] address,
   input  logic [15:0] data_in,
   output logic [15:0] data_out,
   input  logic        iopage_rd,
   input  logic        iopage_wr,
   input  logic        iopage_byte_op,
   output logic        no_decode,
   output logic        interrupt,
   output logic [7:0]  interrupt_ipl,
   output logic [7:0]  vector,
   input  logic [7:0]  ack_ipl,
   input  logic [15:0] psw,
   output logic        psw_io_wr,
   output logic [15:0] psw_wr_data,
   input  logic [15:0] switches,
   output logic [15:0] display,
   input  logic        unibus_to,
   input  logic        memory_to
);

   logic [15:0] clk_data_out;
   logic [15:0] sr_data_out;
   logic [15:0] psw_data_out;
   logic        clk_decode;
   logic        sr_decode;
   logic        psw_decode;
   logic        good_decode;
   logic        clk_interrupt;

   iopage_bus_if bus ();

   // only the offset within the page matters to the devices
   assign bus.iopage_addr = address[12:0];
   assign bus.data_in = data_in;
   assign bus.iopage_rd = iopage_rd;
   assign bus.iopage_wr = iopage_wr;
   assign bus.iopage_byte_op = iopage_byte_op;

   clk_regs clk_regs0
   (
      .clk(clk),
      .reset(reset),
      .bus(bus.device),
      .data_out(clk_data_out),
      .decode(clk_decode),
      .interrupt_req(clk_interrupt),
      .interrupt_ack(ack_ipl[6])
   );

   sr_regs sr_regs0
   (
      .clk(clk),
      .reset(reset),
      .bus(bus.device),
      .data_out(sr_data_out),
      .decode(sr_decode),
      .switches(switches),
      .unibus_to(unibus_to),
      .memory_to(memory_to),
      .display(display)
   );

   psw_regs psw_regs0
   (
      .clk(clk),
      .reset(reset),
      .bus(bus.device),
      .data_out(psw_data_out),
      .decode(psw_decode),
      .psw_in(psw),
      .psw_io_wr(psw_io_wr),
      .psw_wr_data(psw_wr_data)
   );

   assign data_out = clk_decode ? clk_data_out :
                     sr_decode  ? sr_data_out :
                     psw_decode ? psw_data_out :
                     `NO_DEVICE_DATA;

   assign good_decode = clk_decode | sr_decode | psw_decode;
   assign no_decode = (iopage_rd | iopage_wr) & ~good_decode;

   // line clock sits at br6
   assign interrupt = clk_interrupt;
   assign interrupt_ipl = {1'b0, clk_interrupt, 6'b000000};

   // highest pending level supplies the vector
   assign vector = clk_interrupt ? `CLK_VECTOR : 8'h00;

endmodule

// File: verification/tb_clock_gen.sv
// testbench clock and reset
// 10 ns clock, reset held high for the first 16 cycles

`timescale 1ns/10ps

module tb_clock_gen
(
   output logic clk,
   output logic reset
);

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // release on a falling edge away from the DUT sampling edge
   initial
   begin
      reset = 1'b1;
      repeat (16) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
   end

endmodule

// File: verification/iopage_tb.sv
// I/O page testbench
// drives register accesses and compares every cycle against a reference model

`timescale 1ns/10ps
`include "iopage_defs.svh"

module iopage_tb
   import iopage_pkg::*;
();

   localparam int TIMEOUT_CYCLES = 20 * `LINE_CLK_DIV + 2000;
   localparam int POLL_LIMIT = 2 * `LINE_CLK_DIV;
   localparam logic [8:0] PAGE_BASE = 9'h1FF;
   localparam logic [12:0] LKS_OFF = `LKS_OFFSET;
   localparam logic [12:0] SR_OFF = `SR_OFFSET;
   localparam logic [12:0] ERR_OFF = `CPUERR_OFFSET;
   localparam logic [12:0] PSW_OFF = `PSW_OFFSET;

   typedef struct packed
   {
      logic [15:0] display;
      logic        uto;
      logic        nxm;
      logic        ie;
      logic        monitor;
      logic        irq;
      logic        psw_pending;
      logic [15:0] psw_last;
      logic [15:0] div_count;
   } model_state_t;

   logic        clk;
   logic        reset;
   logic [21:0] address;
   logic [15:0] data_in;
   logic [15:0] data_out;
   logic        iopage_rd;
   logic        iopage_wr;
   logic        iopage_byte_op;
   logic        no_decode;
   logic        interrupt;
   logic [7:0]  interrupt_ipl;
   logic [7:0]  vector;
   logic [7:0]  ack_ipl;
   logic [15:0] psw;
   logic        psw_io_wr;
   logic [15:0] psw_wr_data;
   logic [15:0] switches;
   logic [15:0] display;
   logic        unibus_to;
   logic        memory_to;

   model_state_t state;
   logic [31:0]  lcg_state;
   int           errors;
   int           tests_run;
   int           tests_failed;
   int           cycles;
   int           compared;

   tb_clock_gen clock_gen0
   (
      .clk(clk),
      .reset(reset)
   );

   iopage dut0
   (
      .clk(clk),
      .reset(reset),
      .address(address),
      .data_in(data_in),
      .data_out(data_out),
      .iopage_rd(iopage_rd),
      .iopage_wr(iopage_wr),
      .iopage_byte_op(iopage_byte_op),
      .no_decode(no_decode),
      .interrupt(interrupt),
      .interrupt_ipl(interrupt_ipl),
      .vector(vector),
      .ack_ipl(ack_ipl),
      .psw(psw),
      .psw_io_wr(psw_io_wr),
      .psw_wr_data(psw_wr_data),
      .switches(switches),
      .display(display),
      .unibus_to(unibus_to),
      .memory_to(memory_to)
   );

   function automatic logic [15:0] next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state[31:16];
   endfunction

   // byte writes replace only the addressed half
   function automatic logic [15:0] merge_write(input logic [15:0] old, input logic [15:0] din,
                                               input logic byte_op, input logic high);
      if (!byte_op)
         return din;
      else if (high)
         return {din[15:8], old[7:0]};
      else
         return {old[15:8], din[7:0]};
   endfunction

   function automatic logic is_mapped(input logic [12:0] off);
      return off[12:1] == LKS_OFF[12:1] || off[12:1] == SR_OFF[12:1] ||
             off[12:1] == ERR_OFF[12:1] || off[12:1] == PSW_OFF[12:1];
   endfunction

   function automatic void iopage_model
   (
      input  model_state_t s,
      input  logic [21:0]  addr,
      input  logic         rd,
      input  logic         wr,
      input  logic         byte_op,
      input  logic [15:0]  din,
      input  logic [15:0]  psw_in,
      input  logic [15:0]  sw,
      input  logic         uto_in,
      input  logic         nxm_in,
      input  logic         ack,
      output logic [15:0]  exp_data,
      output logic         exp_nd,
      output logic         exp_pwr,
      output logic [15:0]  exp_pdata,
      output model_state_t ns
   );
      logic [12:0] off;
      logic        strobe;
      logic        tick;
      logic        lks_wr;
      psw_word_u   cur;
      psw_word_u   merged;

      off = addr[12:0];
      strobe = rd | wr;
      exp_data = `NO_DEVICE_DATA;
      if (strobe && off[12:1] == LKS_OFF[12:1])
      begin
         exp_data = 16'h0000;
         exp_data[LKS_MONITOR_BIT] = s.monitor;
         exp_data[LKS_IE_BIT] = s.ie;
      end
      else if (strobe && off[12:1] == SR_OFF[12:1])
         exp_data = sw;
      else if (strobe && off[12:1] == ERR_OFF[12:1])
      begin
         exp_data = 16'h0000;
         exp_data[CPUERR_UTO_BIT] = s.uto;
         exp_data[CPUERR_NXM_BIT] = s.nxm;
      end
      else if (strobe && off[12:1] == PSW_OFF[12:1])
         exp_data = s.psw_pending ? s.psw_last : psw_in;
      exp_nd = strobe && !is_mapped(off);

      // T is never writable from the page
      cur.raw = psw_in;
      merged.raw = merge_write(psw_in, din, byte_op, off[0]);
      merged.fields.t = cur.fields.t;
      exp_pwr = wr && off[12:1] == PSW_OFF[12:1];
      exp_pdata = merged.raw;

      ns = s;
      tick = (s.div_count == 16'(`LINE_CLK_DIV - 1));
      ns.div_count = tick ? 16'h0000 : s.div_count + 16'h0001;
      lks_wr = wr && off[12:1] == LKS_OFF[12:1] && !(byte_op && off[0]);
      if (lks_wr)
      begin
         ns.ie = din[LKS_IE_BIT];
         if (!din[LKS_MONITOR_BIT])
            ns.monitor = 1'b0;
      end
      if (tick)
         ns.monitor = 1'b1;
      if (lks_wr && !din[LKS_IE_BIT])
         ns.irq = 1'b0;
      else if (tick && s.ie)
         ns.irq = 1'b1;
      else if (ack)
         ns.irq = 1'b0;
      if (wr && off[12:1] == SR_OFF[12:1])
         ns.display = merge_write(s.display, din, byte_op, off[0]);
      if (wr && off[12:1] == ERR_OFF[12:1])
      begin
         ns.uto = 1'b0;
         ns.nxm = 1'b0;
      end
      else
      begin
         if (uto_in)
            ns.uto = 1'b1;
         if (nxm_in)
            ns.nxm = 1'b1;
      end
      ns.psw_pending = exp_pwr;
      if (exp_pwr)
         ns.psw_last = merged.raw;
   endfunction

   task automatic report_mismatch(input string name, input logic [15:0] got,
                                  input logic [15:0] expected);
      errors++;
      $display("Mismatch %s: got %h, expected %h at cycle %0d", name, got, expected, cycles);
   endtask

   task automatic report_failure(input string what);
      errors++;
      $display("Error at cycle %0d: %s", cycles, what);
   endtask

   task automatic drive(input logic [12:0] off, input logic rd, input logic wr,
                        input logic byte_op, input logic [15:0] din);
      @(negedge clk);
      address = {PAGE_BASE, off};
      iopage_rd = rd;
      iopage_wr = wr;
      iopage_byte_op = byte_op;
      data_in = din;
   endtask

   task automatic word_read(input logic [12:0] off, output logic [15:0] value);
      drive(off, 1'b1, 1'b0, 1'b0, 16'h0000);
      #2;
      value = data_out;
   endtask

   task automatic word_write(input logic [12:0] off, input logic [15:0] din);
      drive(off, 1'b0, 1'b1, 1'b0, din);
   endtask

   task automatic byte_write(input logic [12:0] off, input logic [15:0] din);
      drive(off, 1'b0, 1'b1, 1'b1, din);
   endtask

   task automatic idle(input int n);
      repeat (n) drive(13'h0000, 1'b0, 1'b0, 1'b0, 16'h0000);
   endtask

   task automatic finish_test(input string name, input int errors_at_start);
      idle(1);
      tests_run++;
      if (errors == errors_at_start)
         $display("test %s: ok", name);
      else
      begin
         tests_failed++;
         $display("test %s: %0d errors", name, errors - errors_at_start);
      end
   endtask

   task automatic switch_display_test();
      int          start;
      logic [15:0] value;

      start = errors;
      repeat (8)
      begin
         idle(1);
         switches = next_random();
         word_read(SR_OFF, value);
         word_write(SR_OFF, next_random());
         byte_write(SR_OFF, next_random());
         byte_write(SR_OFF | 13'h0001, next_random());
      end
      finish_test("switch and display", start);
   endtask

   task automatic cpu_error_test();
      int          start;
      logic [15:0] value;

      start = errors;
      word_read(ERR_OFF, value);
      idle(1);
      unibus_to = 1'b1;
      idle(1);
      unibus_to = 1'b0;
      idle(3);
      word_read(ERR_OFF, value);
      memory_to = 1'b1;
      idle(1);
      memory_to = 1'b0;
      idle(4);
      word_read(ERR_OFF, value);
      word_write(ERR_OFF, next_random());
      word_read(ERR_OFF, value);
      finish_test("cpu error register", start);
   endtask

   task automatic psw_window_test();
      int          start;
      logic [15:0] value;

      start = errors;
      repeat (8)
      begin
         idle(1);
         psw = next_random();
         word_read(PSW_OFF, value);
         word_write(PSW_OFF, next_random());
         word_read(PSW_OFF, value);
         byte_write(PSW_OFF, next_random());
         byte_write(PSW_OFF | 13'h0001, next_random());
         word_read(PSW_OFF, value);
         word_read(PSW_OFF, value);
      end
      finish_test("psw window", start);
   endtask

   task automatic line_clock_test();
      int          start;
      int          i;
      logic        found;
      logic [15:0] value;

      start = errors;
      word_write(LKS_OFF, 16'h0000);
      found = 1'b0;
      for (i = 0; i < POLL_LIMIT && !found; i++)
      begin
         word_read(LKS_OFF, value);
         found = value[LKS_MONITOR_BIT];
      end
      if (!found)
         report_failure("line clock monitor bit never set after clearing LKS");

      word_write(LKS_OFF, 16'h0040);
      found = 1'b0;
      for (i = 0; i < POLL_LIMIT && !found; i++)
      begin
         idle(1);
         #2;
         found = interrupt;
      end
      if (!found)
         report_failure("line clock interrupt not raised with IE set");

      idle(1);
      ack_ipl = 8'h40;
      idle(1);
      ack_ipl = 8'h00;
      word_write(LKS_OFF, 16'h0000);
      for (i = 0; i < POLL_LIMIT; i++)
      begin
         idle(1);
         #2;
         if (interrupt)
            report_failure("line clock interrupt raised with IE clear");
      end
      finish_test("line clock", start);
   endtask

   task automatic unmapped_test();
      int          start;
      logic [15:0] r;
      logic [15:0] value;

      start = errors;
      repeat (16)
      begin
         r = next_random();
         if (!is_mapped(r[12:0]))
         begin
            if (r[15])
               word_read(r[12:0], value);
            else
               word_write(r[12:0], next_random());
            drive(r[12:0], 1'b0, 1'b0, 1'b0, 16'h0000);
         end
      end
      finish_test("unmapped addresses", start);
   endtask

   // reference model and compare just before each rising edge
   initial
   begin
      logic [15:0]  exp_data;
      logic         exp_nd;
      logic         exp_pwr;
      logic [15:0]  exp_pdata;
      model_state_t next_state;

      state = '0;
      compared = 0;
      forever
      begin
         @(negedge clk);
         #4;
         if (reset)
            state = '0;
         else
         begin
            iopage_model(state, address, iopage_rd, iopage_wr, iopage_byte_op, data_in, psw,
                         switches, unibus_to, memory_to, ack_ipl[6],
                         exp_data, exp_nd, exp_pwr, exp_pdata, next_state);
            compared++;
            if (data_out !== exp_data)
               report_mismatch("data_out", data_out, exp_data);
            if (no_decode !== exp_nd)
               report_mismatch("no_decode", 16'(no_decode), 16'(exp_nd));
            if (interrupt !== state.irq)
               report_mismatch("interrupt", 16'(interrupt), 16'(state.irq));
            if (interrupt_ipl !== {1'b0, state.irq, 6'b000000})
               report_mismatch("interrupt_ipl", 16'(interrupt_ipl), 16'({state.irq, 6'b0}));
            if (vector !== (state.irq ? `CLK_VECTOR : 8'h00))
               report_mismatch("vector", 16'(vector), state.irq ? 16'(`CLK_VECTOR) : 16'h0);
            if (psw_io_wr !== exp_pwr)
               report_mismatch("psw_io_wr", 16'(psw_io_wr), 16'(exp_pwr));
            if (exp_pwr && psw_wr_data !== exp_pdata)
               report_mismatch("psw_wr_data", psw_wr_data, exp_pdata);
            if (display !== state.display)
               report_mismatch("display", display, state.display);
            state = next_state;
         end
      end
   end

   initial
   begin
      cycles = 0;
      while (cycles < TIMEOUT_CYCLES)
      begin
         @(posedge clk);
         cycles++;
      end
      $display("run stopped after %0d cycles without finishing the tests", cycles);
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial
   begin
      address = '0;
      data_in = '0;
      iopage_rd = 1'b0;
      iopage_wr = 1'b0;
      iopage_byte_op = 1'b0;
      ack_ipl = '0;
      psw = '0;
      switches = '0;
      unibus_to = 1'b0;
      memory_to = 1'b0;
      errors = 0;
      tests_run = 0;
      tests_failed = 0;
      lcg_state = 32'h57a0;

      while (reset !== 1'b0)
         @(posedge clk);

      switch_display_test();
      cpu_error_test();
      psw_window_test();
      line_clock_test();
      unmapped_test();

      $display("tests run %0d, failed %0d, cycles compared %0d, errors %0d",
               tests_run, tests_failed, compared, errors);
      if (errors == 0 && tests_failed == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

// File: iopage.f
+incdir+source
source/iopage_pkg.sv
source/iopage_bus_if.sv
source/clk_regs.sv
source/sr_regs.sv
source/psw_regs.sv
source/iopage.sv
verification/tb_clock_gen.sv
verification/iopage_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile the I/O page testbench with Verilator and run it
# the run fails when the log holds the failure report

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f iopage.f --top-module iopage_tb -o iopage_sim
if [ $? -ne 0 ]; then
   echo "verilator compile failed"
   exit 1
fi

./obj_dir/iopage_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
   echo "simulation reported failures"
   exit 1
fi

exit 0
